//--- tests/chdr_ctrl_testdata.txt
# Columns: tag, data in hex, tlast. C = CHDR in, K = control in,
# O = expected control out, P = expected CHDR out. i_this_epid is 00c3
# CHDR pkt, no metadata, 4 control words
C 0080000000180007 0
C 000000ab01104834 0
C 12345678dead0001 1
O 01101434 0
O 001200ab 0
O dead0001 0
O 12345678 1
# CHDR pkt, two metadata words, length 36 so half last beat
C 0082000100240007 0
C 1111111111111111 0
C 2222222222222222 0
C 0000beef02000c10 0
C ffffffffcafe0002 1
O 02001410 0
O 0003beef 0
O cafe0002 1
# Truncated in metadata, then a clean packet
C 0082000200300007 0
C 3333333333333333 1
C 0080000300180009 0
C 0000004203100402 0
C 0000000400000003 1
O 03101402 0
O 00010042 0
O 00000003 0
O 00000004 1
# Control pkt with HasTime, NumData 2, seq 0
K 45201c09 0
K 00210123 0
K 11110000 0
K 22220000 0
K 33330000 0
K 44440000 0
K 55550000 1
P 0080000000280123 0
P 000000c345201c21 0
P 2222000011110000 0
P 4444000033330000 0
P 0000000055550000 1
# Control pkt, NumData 1, seq 1
K 06101c09 0
K 00020456 0
K aaaa0000 0
K bbbb0000 1
P 0080000100180456 0
P 000000c306101c02 0
P bbbb0000aaaa0000 1
# Control pkt, NumData 0, seq 2
K 07001c09 0
K 03ffffff 0
K cccc0000 1
P 008000020018ffff 0
P 000000c307001fff 0
P 00000000cccc0000 1

//--- vlog.f
design/chdr_pkg.sv
design/axis_ctrl_pkg.sv
design/axis_reg_slice.sv
design/ctrl_downsizer.sv
design/ctrl_upsizer.sv
design/chdr_to_ctrl_path.sv
design/ctrl_to_chdr_path.sv
design/chdr_ctrl_bridge.sv
tests/tb_chdr_ctrl_bridge.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_chdr_ctrl_bridge
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_chdr_ctrl_bridge.sv
// Testbench for the CHDR to AXIS-Control bridge
// Stimulus and expected words come from tests/chdr_ctrl_testdata.txt
// Run from the project root so the data file path resolves
// i_this_epid is fixed at 16'h00c3 to match the expected data
`default_nettype none

module tb_chdr_ctrl_bridge
  import chdr_pkg::*, axis_ctrl_pkg::*;
();

  localparam int TIMEOUT = 2000;

  logic       rfnoc_chdr_clk;
  logic       rfnoc_chdr_rst;
  chdr_epid_t this_epid;
  chdr_word_t chdr_in_tdata;
  logic       chdr_in_tlast;
  logic       chdr_in_tvalid;
  logic       chdr_in_tready;
  chdr_word_t chdr_out_tdata;
  logic       chdr_out_tlast;
  logic       chdr_out_tvalid;
  logic       chdr_out_tready;
  ctrl_word_t ctrl_in_tdata;
  logic       ctrl_in_tlast;
  logic       ctrl_in_tvalid;
  logic       ctrl_in_tready;
  ctrl_word_t ctrl_out_tdata;
  logic       ctrl_out_tlast;
  logic       ctrl_out_tvalid;
  logic       ctrl_out_tready;

  // Data file beats with tlast in bit 64
  logic [64:0] chdr_in_q[$];
  logic [64:0] ctrl_in_q[$];
  logic [64:0] exp_ctrl_q[$];
  logic [64:0] exp_chdr_q[$];
  int          errors;
  logic        stim_done = 1'b0;

  chdr_ctrl_bridge i_dut (
    .rfnoc_chdr_clk(rfnoc_chdr_clk), .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_this_epid(this_epid),
    .i_chdr_tdata(chdr_in_tdata), .i_chdr_tlast(chdr_in_tlast),
    .i_chdr_tvalid(chdr_in_tvalid), .o_chdr_tready(chdr_in_tready),
    .o_chdr_tdata(chdr_out_tdata), .o_chdr_tlast(chdr_out_tlast),
    .o_chdr_tvalid(chdr_out_tvalid), .i_chdr_tready(chdr_out_tready),
    .i_ctrl_tdata(ctrl_in_tdata), .i_ctrl_tlast(ctrl_in_tlast),
    .i_ctrl_tvalid(ctrl_in_tvalid), .o_ctrl_tready(ctrl_in_tready),
    .o_ctrl_tdata(ctrl_out_tdata), .o_ctrl_tlast(ctrl_out_tlast),
    .o_ctrl_tvalid(ctrl_out_tvalid), .i_ctrl_tready(ctrl_out_tready)
  );

  initial begin
    rfnoc_chdr_clk = 1'b0;
    forever #4 rfnoc_chdr_clk = !rfnoc_chdr_clk;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic load_testdata();
    int         fd;
    int         n;
    string      line;
    logic [7:0] tag;
    logic [63:0] val;
    logic [0:0] last;
    fd = $fopen("tests/chdr_ctrl_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the test data file");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h", tag, val, last);
          // Tag selects the queue as listed in the data file header
          case (tag)
            "C": chdr_in_q.push_back({last, val});
            "K": ctrl_in_q.push_back({last, val});
            "O": exp_ctrl_q.push_back({last, val});
            "P": exp_chdr_q.push_back({last, val});
            default: $display("Skipping unknown data line: %s", line);
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------
  // Drivers
  // --------------------
  task automatic send_chdr_beats();
    int waited;
    logic [64:0] beat;
    while (chdr_in_q.size() > 0) begin
      beat = chdr_in_q.pop_front();
      chdr_in_tdata  <= beat[63:0];
      chdr_in_tlast  <= beat[64];
      chdr_in_tvalid <= 1'b1;
      waited = 0;
      do begin
        @(posedge rfnoc_chdr_clk);
        waited++;
      end while (!chdr_in_tready && waited <= TIMEOUT);
      if (!chdr_in_tready) begin
        report_timeout("CHDR input ready");
        chdr_in_q.delete();
      end
    end
    chdr_in_tvalid <= 1'b0;
  endtask

  task automatic send_ctrl_words();
    int waited;
    logic [64:0] beat;
    while (ctrl_in_q.size() > 0) begin
      beat = ctrl_in_q.pop_front();
      ctrl_in_tdata  <= beat[31:0];
      ctrl_in_tlast  <= beat[64];
      ctrl_in_tvalid <= 1'b1;
      waited = 0;
      do begin
        @(posedge rfnoc_chdr_clk);
        waited++;
      end while (!ctrl_in_tready && waited <= TIMEOUT);
      if (!ctrl_in_tready) begin
        report_timeout("control input ready");
        ctrl_in_q.delete();
      end
    end
    ctrl_in_tvalid <= 1'b0;
  endtask

  // --------------------
  // Monitors
  // --------------------
  task automatic watch_ctrl_out();
    int waited;
    logic [64:0] exp;
    while (exp_ctrl_q.size() > 0) begin
      waited = 0;
      do begin
        @(posedge rfnoc_chdr_clk);
        waited++;
      end while (!(ctrl_out_tvalid && ctrl_out_tready) && waited <= TIMEOUT);
      if (ctrl_out_tvalid && ctrl_out_tready) begin
        exp = exp_ctrl_q.pop_front();
        check_value("o_ctrl_tdata", {32'd0, ctrl_out_tdata}, {32'd0, exp[31:0]});
        check_value("o_ctrl_tlast", {63'd0, ctrl_out_tlast}, {63'd0, exp[64]});
      end else begin
        report_timeout("a control output word");
        exp_ctrl_q.delete();
      end
    end
  endtask

  task automatic watch_chdr_out();
    int waited;
    logic [64:0] exp;
    while (exp_chdr_q.size() > 0) begin
      waited = 0;
      do begin
        @(posedge rfnoc_chdr_clk);
        waited++;
      end while (!(chdr_out_tvalid && chdr_out_tready) && waited <= TIMEOUT);
      if (chdr_out_tvalid && chdr_out_tready) begin
        exp = exp_chdr_q.pop_front();
        check_value("o_chdr_tdata", chdr_out_tdata, exp[63:0]);
        check_value("o_chdr_tlast", {63'd0, chdr_out_tlast}, {63'd0, exp[64]});
      end else begin
        report_timeout("a CHDR output beat");
        exp_chdr_q.delete();
      end
    end
  endtask

  // Random back-pressure on both outputs
  initial begin
    void'($urandom(32'hc6ad));
    chdr_out_tready = 1'b0;
    ctrl_out_tready = 1'b0;
    while (!stim_done) begin
      @(posedge rfnoc_chdr_clk);
      chdr_out_tready <= ($urandom % 4) != 32'd0;
      ctrl_out_tready <= ($urandom % 4) != 32'd0;
    end
  end

  initial begin
    errors         = 0;
    rfnoc_chdr_rst = 1'b1;
    this_epid      = 16'h00c3;
    chdr_in_tdata  = '0;
    chdr_in_tlast  = 1'b0;
    chdr_in_tvalid = 1'b0;
    ctrl_in_tdata  = '0;
    ctrl_in_tlast  = 1'b0;
    ctrl_in_tvalid = 1'b0;
    load_testdata();
    repeat (3) @(posedge rfnoc_chdr_clk);
    rfnoc_chdr_rst <= 1'b0;
    @(posedge rfnoc_chdr_clk);
    fork
      send_chdr_beats();
      send_ctrl_words();
      watch_ctrl_out();
      watch_chdr_out();
    join
    // Nothing extra may follow the expected words
    repeat (40) begin
      @(posedge rfnoc_chdr_clk);
      if (ctrl_out_tvalid && ctrl_out_tready) begin
        errors++;
        $display("Unexpected extra control output word %h", ctrl_out_tdata);
      end
      if (chdr_out_tvalid && chdr_out_tready) begin
        errors++;
        $display("Unexpected extra CHDR output beat %h", chdr_out_tdata);
      end
    end
    stim_done = 1'b1;
    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/chdr_ctrl_bridge.sv
// Bridge between a 64-bit CHDR stream and a 32-bit AXIS-Control stream
// Single clock domain, both directions run on rfnoc_chdr_clk
// i_this_epid is the CHDR endpoint ID used for control responses
`default_nettype none

module chdr_ctrl_bridge
  import chdr_pkg::*, axis_ctrl_pkg::*;
(
  input  wire             rfnoc_chdr_clk,
  input  wire             rfnoc_chdr_rst,
  input  wire chdr_epid_t i_this_epid,
  // CHDR in and out
  input  wire chdr_word_t i_chdr_tdata,
  input  wire             i_chdr_tlast,
  input  wire             i_chdr_tvalid,
  output logic            o_chdr_tready,
  output chdr_word_t      o_chdr_tdata,
  output logic            o_chdr_tlast,
  output logic            o_chdr_tvalid,
  input  wire             i_chdr_tready,
  // Control in and out
  input  wire ctrl_word_t i_ctrl_tdata,
  input  wire             i_ctrl_tlast,
  input  wire             i_ctrl_tvalid,
  output logic            o_ctrl_tready,
  output ctrl_word_t      o_ctrl_tdata,
  output logic            o_ctrl_tlast,
  output logic            o_ctrl_tvalid,
  input  wire             i_ctrl_tready
);

  // --------------------
  // CHDR to control
  // --------------------
  chdr_word_t ch2ct_tdata;
  logic       ch2ct_tlast;
  logic       ch2ct_tvalid;
  logic       ch2ct_tready;
  chdr_word_t dn_tdata;
  logic       dn_half;
  logic       dn_tlast;
  logic       dn_tvalid;
  logic       dn_tready;

  axis_reg_slice in_slice (
    .rfnoc_chdr_clk(rfnoc_chdr_clk), .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_tdata(i_chdr_tdata), .i_tlast(i_chdr_tlast), .i_tvalid(i_chdr_tvalid),
    .o_tready_up(o_chdr_tready),
    .o_tdata(ch2ct_tdata), .o_tlast(ch2ct_tlast), .o_tvalid(ch2ct_tvalid),
    .i_tready(ch2ct_tready)
  );

  chdr_to_ctrl_path ch2ct_path (
    .rfnoc_chdr_clk(rfnoc_chdr_clk), .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_tdata(ch2ct_tdata), .i_tlast(ch2ct_tlast), .i_tvalid(ch2ct_tvalid),
    .o_tready(ch2ct_tready),
    .o_tdata(dn_tdata), .o_half(dn_half), .o_tlast(dn_tlast), .o_tvalid(dn_tvalid),
    .i_tready(dn_tready)
  );

  ctrl_downsizer downsizer (
    .rfnoc_chdr_clk(rfnoc_chdr_clk), .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_tdata(dn_tdata), .i_half(dn_half), .i_tlast(dn_tlast), .i_tvalid(dn_tvalid),
    .o_tready(dn_tready),
    .o_tdata(o_ctrl_tdata), .o_tlast(o_ctrl_tlast), .o_tvalid(o_ctrl_tvalid),
    .i_tready(i_ctrl_tready)
  );

  // --------------------
  // Control to CHDR
  // --------------------
  chdr_word_t up_tdata;
  logic       up_tlast;
  logic       up_tvalid;
  logic       up_tready;
  chdr_word_t ct2ch_tdata;
  logic       ct2ch_tlast;
  logic       ct2ch_tvalid;
  logic       ct2ch_tready;

  ctrl_upsizer upsizer (
    .rfnoc_chdr_clk(rfnoc_chdr_clk), .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_tdata(i_ctrl_tdata), .i_tlast(i_ctrl_tlast), .i_tvalid(i_ctrl_tvalid),
    .o_tready(o_ctrl_tready),
    .o_tdata(up_tdata), .o_tlast(up_tlast), .o_tvalid(up_tvalid),
    .i_tready(up_tready)
  );

  ctrl_to_chdr_path ct2ch_path (
    .rfnoc_chdr_clk(rfnoc_chdr_clk), .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_this_epid(i_this_epid),
    .i_tdata(up_tdata), .i_tlast(up_tlast), .i_tvalid(up_tvalid),
    .o_tready(up_tready),
    .o_tdata(ct2ch_tdata), .o_tlast(ct2ch_tlast), .o_tvalid(ct2ch_tvalid),
    .i_tready(ct2ch_tready)
  );

  axis_reg_slice out_slice (
    .rfnoc_chdr_clk(rfnoc_chdr_clk), .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_tdata(ct2ch_tdata), .i_tlast(ct2ch_tlast), .i_tvalid(ct2ch_tvalid),
    .o_tready_up(ct2ch_tready),
    .o_tdata(o_chdr_tdata), .o_tlast(o_chdr_tlast), .o_tvalid(o_chdr_tvalid),
    .i_tready(i_chdr_tready)
  );

endmodule

`default_nettype wire

//--- design/ctrl_to_chdr_path.sv
// Wraps upsized control packets into CHDR packets
// First beat is held while the generated CHDR header goes out
// No metadata, no timestamp in the CHDR header, flags and VC zero
`default_nettype none

module ctrl_to_chdr_path
  import chdr_pkg::*, axis_ctrl_pkg::*;
(
  input  wire             rfnoc_chdr_clk,
  input  wire             rfnoc_chdr_rst,
  input  wire chdr_epid_t i_this_epid,
  input  wire chdr_word_t i_tdata,
  input  wire             i_tlast,
  input  wire             i_tvalid,
  output logic            o_tready,
  output chdr_word_t      o_tdata,
  output logic            o_tlast,
  output logic            o_tvalid,
  input  wire             i_tready
);

  typedef enum logic [1:0] {
    ST_CHDR_HDR,
    ST_CTRL_HDR,
    ST_CTRL_BODY
  } state_t;

  state_t       state;
  chdr_seqnum_t seqnum;
  ctrl_word_t   w0;
  ctrl_word_t   w1;
  logic [7:0]   lines32;
  logic [7:0]   lines64;
  chdr_length_t chdr_len;
  logic         out_fire;

  assign w0 = i_tdata[31:0];
  assign w1 = i_tdata[63:32];

  // Input beat only consumed once the CHDR header has left
  assign o_tvalid = i_tvalid;
  assign o_tready = (state != ST_CHDR_HDR) && i_tready;
  assign o_tlast  = (state != ST_CHDR_HDR) && i_tlast;
  assign out_fire = o_tvalid && i_tready;

  // --------------------
  // CHDR length
  // --------------------
  assign lines32 = CTRL_FIXED_LINES
                 + (ctrl_get_has_time(w0) ? CTRL_TS_LINES : 8'd0)
                 + {4'd0, ctrl_get_num_data(w0)};
  // CHDR header line plus control lines rounded up to 64 bits
  assign lines64  = 8'd1 + {1'b0, lines32[7:1]} + {7'd0, lines32[0]};
  assign chdr_len = {5'd0, lines64, 3'd0};

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state  <= ST_CHDR_HDR;
      seqnum <= '0;
    end else if (out_fire) begin
      case (state)
        ST_CHDR_HDR: begin
          state <= ST_CTRL_HDR;
        end
        ST_CTRL_HDR: begin
          state <= i_tlast ? ST_CHDR_HDR : ST_CTRL_BODY;
        end
        ST_CTRL_BODY: begin
          if (i_tlast) begin
            state <= ST_CHDR_HDR;
          end
        end
        default: begin
          state <= ST_CHDR_HDR;
        end
      endcase
      // One sequence number per packet
      if (o_tlast) begin
        seqnum <= seqnum + 16'd1;
      end
    end
  end

  always_comb begin
    case (state)
      ST_CHDR_HDR: begin
        o_tdata = chdr_build_header(CHDR_PKT_TYPE_CTRL, 5'd0, seqnum, chdr_len,
                                    ctrl_get_rem_dst_epid(w1));
      end
      ST_CTRL_HDR: begin
        // Forward to the remote port with the return path via this endpoint
        o_tdata = {
          ctrl_build_hdr_hi(10'd0, i_this_epid),
          ctrl_build_hdr_lo(
            ctrl_get_is_ack(w0),
            ctrl_get_has_time(w0),
            ctrl_get_seq_num(w0),
            ctrl_get_num_data(w0),
            ctrl_get_src_port(w0),
            ctrl_get_rem_dst_port(w1)
          )
        };
      end
      default: begin
        o_tdata = i_tdata;
      end
    endcase
  end

  // Op word always follows the header pair so the held first beat never ends a packet
  assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    (i_tvalid && state == ST_CHDR_HDR) |-> !i_tlast);

endmodule

`default_nettype wire

//--- design/chdr_to_ctrl_path.sv
// Parses incoming CHDR control packets for the AXIS-Control side
// CHDR header and metadata are dropped and the control header is rewritten
// Timestamps in the CHDR header are ignored
`default_nettype none

module chdr_to_ctrl_path
  import chdr_pkg::*, axis_ctrl_pkg::*;
(
  input  wire             rfnoc_chdr_clk,
  input  wire             rfnoc_chdr_rst,
  input  wire chdr_word_t i_tdata,
  input  wire             i_tlast,
  input  wire             i_tvalid,
  output logic            o_tready,
  output chdr_word_t      o_tdata,
  output logic            o_half,
  output logic            o_tlast,
  output logic            o_tvalid,
  input  wire             i_tready
);

  typedef enum logic [1:0] {
    ST_CHDR_HDR,
    ST_CHDR_MDATA,
    ST_CTRL_HDR,
    ST_CTRL_BODY
  } state_t;

  state_t       state;
  chdr_nmdata_t mdata_left;
  chdr_length_t pkt_len;
  logic         in_ctrl;
  logic         in_fire;
  ctrl_word_t   hdr_lo;
  ctrl_word_t   hdr_hi;

  // CHDR header and metadata consumed without output
  assign in_ctrl  = (state == ST_CTRL_HDR) || (state == ST_CTRL_BODY);
  assign o_tready = in_ctrl ? i_tready : 1'b1;
  assign in_fire  = i_tvalid && o_tready;
  assign o_tvalid = i_tvalid && in_ctrl;
  assign o_tlast  = i_tlast;
  // Length mod 8 of 4 leaves the upper half of the last beat empty
  assign o_half   = i_tlast && (pkt_len[2:0] == 3'd4);

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state <= ST_CHDR_HDR;
    end else if (in_fire) begin
      case (state)
        ST_CHDR_HDR: begin
          // tlast here is a truncated packet
          if (i_tlast) begin
            state <= ST_CHDR_HDR;
          end else if (chdr_get_num_mdata(i_tdata) == 5'd0) begin
            state <= ST_CTRL_HDR;
          end else begin
            state <= ST_CHDR_MDATA;
          end
        end
        ST_CHDR_MDATA: begin
          if (i_tlast) begin
            state <= ST_CHDR_HDR;
          end else if (mdata_left == 5'd1) begin
            state <= ST_CTRL_HDR;
          end
        end
        ST_CTRL_HDR: begin
          state <= i_tlast ? ST_CHDR_HDR : ST_CTRL_BODY;
        end
        ST_CTRL_BODY: begin
          if (i_tlast) begin
            state <= ST_CHDR_HDR;
          end
        end
        default: begin
          state <= ST_CHDR_HDR;
        end
      endcase
    end
  end

  // Metadata countdown and length captured from the CHDR header
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (in_fire && (state == ST_CHDR_HDR)) begin
      mdata_left <= chdr_get_num_mdata(i_tdata);
      pkt_len    <= chdr_get_length(i_tdata);
    end else if (in_fire && (state == ST_CHDR_MDATA)) begin
      mdata_left <= mdata_left - 5'd1;
    end
  end

  // --------------------
  // Control header rewrite
  // --------------------
  // Request keeps its DstPort and its response returns through this port
  assign hdr_lo = ctrl_build_hdr_lo(
    ctrl_get_is_ack(i_tdata[31:0]),
    ctrl_get_has_time(i_tdata[31:0]),
    ctrl_get_seq_num(i_tdata[31:0]),
    ctrl_get_num_data(i_tdata[31:0]),
    THIS_PORTID,
    ctrl_get_dst_port(i_tdata[31:0])
  );
  // Remote return path from the CHDR source fields
  assign hdr_hi = ctrl_build_hdr_hi(
    ctrl_get_src_port(i_tdata[31:0]),
    ctrl_get_rem_dst_epid(i_tdata[63:32])
  );

  assign o_tdata = (state == ST_CTRL_HDR) ? {hdr_hi, hdr_lo} : i_tdata;

  // Metadata state always has words left to drop
  assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    (state == ST_CHDR_MDATA) |-> (mdata_left != 5'd0));

endmodule

`default_nettype wire

//--- design/ctrl_upsizer.sv
// Packs pairs of 32-bit control words into 64-bit beats
// First word of a pair lands in the low half
// An odd last word goes out with a zero upper half
`default_nettype none

module ctrl_upsizer
  import chdr_pkg::*, axis_ctrl_pkg::*;
(
  input  wire             rfnoc_chdr_clk,
  input  wire             rfnoc_chdr_rst,
  input  wire ctrl_word_t i_tdata,
  input  wire             i_tlast,
  input  wire             i_tvalid,
  output logic            o_tready,
  output chdr_word_t      o_tdata,
  output logic            o_tlast,
  output logic            o_tvalid,
  input  wire             i_tready
);

  ctrl_word_t lo_tdata;
  logic       lo_valid;
  logic       in_fire;
  logic       emit;

  // Output register must be free or leaving
  assign o_tready = !o_tvalid || i_tready;
  assign in_fire  = i_tvalid && o_tready;
  // Completes a beat on the high word or an early tlast
  assign emit     = in_fire && (lo_valid || i_tlast);

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      lo_valid <= 1'b0;
      o_tvalid <= 1'b0;
    end else begin
      if (in_fire) begin
        lo_valid <= !lo_valid && !i_tlast;
      end
      if (emit) begin
        o_tvalid <= 1'b1;
      end else if (i_tready) begin
        o_tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (in_fire && !lo_valid) begin
      lo_tdata <= i_tdata;
    end
    if (emit) begin
      o_tdata <= lo_valid ? {i_tdata, lo_tdata} : {32'd0, i_tdata};
      o_tlast <= i_tlast;
    end
  end

endmodule

`default_nettype wire

//--- design/ctrl_downsizer.sv
// Splits 64-bit beats into 32-bit control words, low half first
// i_half marks a last beat whose upper half carries nothing
`default_nettype none

module ctrl_downsizer
  import chdr_pkg::*, axis_ctrl_pkg::*;
(
  input  wire             rfnoc_chdr_clk,
  input  wire             rfnoc_chdr_rst,
  input  wire chdr_word_t i_tdata,
  input  wire             i_half,
  input  wire             i_tlast,
  input  wire             i_tvalid,
  output logic            o_tready,
  output ctrl_word_t      o_tdata,
  output logic            o_tlast,
  output logic            o_tvalid,
  input  wire             i_tready
);

  chdr_word_t buf_tdata;
  logic       buf_half;
  logic       buf_tlast;
  // Low half on output while clear, high half while set
  logic       phase;
  logic       beat_done;
  logic       in_fire;

  // Final word of the held beat leaves this cycle
  assign beat_done = o_tvalid && i_tready && (phase || buf_half);
  assign o_tready  = !o_tvalid || beat_done;
  assign in_fire   = i_tvalid && o_tready;

  assign o_tdata = phase ? buf_tdata[63:32] : buf_tdata[31:0];
  assign o_tlast = buf_tlast && (phase || buf_half);

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      o_tvalid <= 1'b0;
      phase    <= 1'b0;
    end else if (in_fire) begin
      o_tvalid <= 1'b1;
      phase    <= 1'b0;
    end else if (beat_done) begin
      o_tvalid <= 1'b0;
      phase    <= 1'b0;
    end else if (o_tvalid && i_tready) begin
      phase <= 1'b1;
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (in_fire) begin
      buf_tdata <= i_tdata;
      buf_half  <= i_half;
      buf_tlast <= i_tlast;
    end
  end

endmodule

`default_nettype wire

//--- design/axis_reg_slice.sv
// One-entry AXI-Stream register slice for the 64-bit CHDR bus
// Upstream ready comes from a flop, one word of skid storage absorbs it
`default_nettype none

module axis_reg_slice
  import chdr_pkg::*;
(
  input  wire             rfnoc_chdr_clk,
  input  wire             rfnoc_chdr_rst,
  input  wire chdr_word_t i_tdata,
  input  wire             i_tlast,
  input  wire             i_tvalid,
  output logic            o_tready_up,
  output chdr_word_t      o_tdata,
  output logic            o_tlast,
  output logic            o_tvalid,
  input  wire             i_tready
);

  chdr_word_t skid_tdata;
  logic       skid_tlast;
  logic       skid_valid;

  // Skid entry occupied means upstream must wait
  assign o_tready_up = !skid_valid;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      o_tvalid   <= 1'b0;
      skid_valid <= 1'b0;
    end else if (skid_valid) begin
      // Drain skid into the output stage while output stays valid
      if (i_tready) begin
        skid_valid <= 1'b0;
      end
    end else if (o_tvalid && !i_tready) begin
      // Park a new input in skid while the output is stalled
      skid_valid <= i_tvalid;
    end else begin
      o_tvalid <= i_tvalid;
    end
  end

  // Payload follows the same decisions
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (skid_valid) begin
      if (i_tready) begin
        o_tdata <= skid_tdata;
        o_tlast <= skid_tlast;
      end
    end else if (o_tvalid && !i_tready) begin
      skid_tdata <= i_tdata;
      skid_tlast <= i_tlast;
    end else begin
      o_tdata <= i_tdata;
      o_tlast <= i_tlast;
    end
  end

  // Held beat must not change under back-pressure
  assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    (o_tvalid && !i_tready) |=> $stable(o_tdata));

endmodule

`default_nettype wire

//--- design/axis_ctrl_pkg.sv
// AXIS-Control header definitions for 32-bit control words
// Word 0 carries routing and sizing, word 1 the remote return path
// THIS_PORTID is fixed at build time
`default_nettype none

package axis_ctrl_pkg;
  import chdr_pkg::*;

  typedef logic [31:0] ctrl_word_t;
  typedef logic [9:0]  ctrl_port_t;
  typedef logic [5:0]  ctrl_seqnum_t;
  typedef logic [3:0]  ctrl_numdata_t;

  // Crossbar port of this bridge
  localparam ctrl_port_t THIS_PORTID = 10'd5;

  // Header pair plus op word
  localparam logic [7:0] CTRL_FIXED_LINES = 8'd3;
  // Timestamp occupies two control lines
  localparam logic [7:0] CTRL_TS_LINES    = 8'd2;

  // --------------------
  // Header word 0
  // --------------------
  function automatic logic ctrl_get_is_ack(input ctrl_word_t w);
    return w[31];
  endfunction

  function automatic logic ctrl_get_has_time(input ctrl_word_t w);
    return w[30];
  endfunction

  function automatic ctrl_seqnum_t ctrl_get_seq_num(input ctrl_word_t w);
    return w[29:24];
  endfunction

  function automatic ctrl_numdata_t ctrl_get_num_data(input ctrl_word_t w);
    return w[23:20];
  endfunction

  function automatic ctrl_port_t ctrl_get_src_port(input ctrl_word_t w);
    return w[19:10];
  endfunction

  function automatic ctrl_port_t ctrl_get_dst_port(input ctrl_word_t w);
    return w[9:0];
  endfunction

  function automatic ctrl_word_t ctrl_build_hdr_lo(
    input logic          is_ack,
    input logic          has_time,
    input ctrl_seqnum_t  seq_num,
    input ctrl_numdata_t num_data,
    input ctrl_port_t    src_port,
    input ctrl_port_t    dst_port
  );
    return {is_ack, has_time, seq_num, num_data, src_port, dst_port};
  endfunction

  // --------------------
  // Header word 1
  // --------------------
  function automatic ctrl_port_t ctrl_get_rem_dst_port(input ctrl_word_t w);
    return w[25:16];
  endfunction

  // Same bit position holds SrcEPID on the CHDR side
  function automatic chdr_epid_t ctrl_get_rem_dst_epid(input ctrl_word_t w);
    return w[15:0];
  endfunction

  function automatic ctrl_word_t ctrl_build_hdr_hi(
    input ctrl_port_t rem_dst_port,
    input chdr_epid_t rem_dst_epid
  );
    return {6'd0, rem_dst_port, rem_dst_epid};
  endfunction

endpackage

`default_nettype wire

//--- design/chdr_pkg.sv
// CHDR definitions for a bus fixed at 64 bits
// Only the header fields the control bridge touches have accessors
// VC, EOB and EOV are always generated as zero
`default_nettype none

package chdr_pkg;

  // Bus width with no wider CHDR variants
  localparam int CHDR_W = 64;

  typedef logic [CHDR_W-1:0] chdr_word_t;
  typedef logic [15:0]       chdr_epid_t;
  typedef logic [15:0]       chdr_seqnum_t;
  typedef logic [15:0]       chdr_length_t;
  typedef logic [4:0]        chdr_nmdata_t;
  typedef logic [2:0]        chdr_pkt_type_t;

  // Control transaction packet type
  localparam chdr_pkt_type_t CHDR_PKT_TYPE_CTRL = 3'd4;

  // --------------------
  // Header field access
  // --------------------
  function automatic chdr_nmdata_t chdr_get_num_mdata(input chdr_word_t hdr);
    return hdr[52:48];
  endfunction

  function automatic chdr_length_t chdr_get_length(input chdr_word_t hdr);
    return hdr[31:16];
  endfunction

  // Layout: VC, EOB, EOV, type, NumMData, SeqNum, Length, DstEPID
  function automatic chdr_word_t chdr_build_header(
    input chdr_pkt_type_t pkt_type,
    input chdr_nmdata_t   nmdata,
    input chdr_seqnum_t   seqnum,
    input chdr_length_t   length,
    input chdr_epid_t     dst_epid
  );
    return {6'd0, 1'b0, 1'b0, pkt_type, nmdata, seqnum, length, dst_epid};
  endfunction

endpackage

`default_nettype wire
